//--- logic/branch_predict.sv
/*
  Next fetch address with static prediction: backward branches taken, forward not,
  jal always. jalr uses the return stack or waits for a resolved target.
  mispredict is suppressed in a cycle that also carries an exception
*/
`timescale 1ns/1ns

module branch_predict import fetch_pkg::*; import decode_pkg::*; #(
	parameter addr_t reset_vector = 64'h8000_0000,
	parameter int    queue_aw     = 2,
	parameter int    stack_aw     = 2
) (
	input  logic       CLK,
	input  logic       rst,
	input  predec_t    pd,
	input  logic       pd_valid,
	input  resolve_t   res,
	input  logic       exc_valid,
	input  addr_t      exc_pc,
	output fetch_req_t req,
	output logic       req_valid,
	output logic       mispredict
);

	predec_t   pend_q;        // instruction held across a stall
	predec_t   cur;
	logic      pend_valid_q;
	logic      cur_valid;
	logic      boot_q;        // first request after reset
	logic      redir_q;       // a word in predecode may belong to the old path
	logic      use_ras;
	logic      pred_taken;
	logic      jalr_stall;
	logic      queue_stall;
	logic      issue;
	logic      redirect;
	logic      q_full;
	logic      ras_push;
	logic      ras_pop;
	logic      ras_empty;
	addr_t     seq_addr;
	addr_t     taken_addr;
	addr_t     next_addr;
	addr_t     redirect_addr;
	addr_t     ras_top;
	pred_rec_t head;
	pred_rec_t rec;

	assign cur_valid = (pd_valid && !redir_q) || pend_valid_q;
	assign cur       = pend_valid_q ? pend_q : pd;

	assign use_ras    = cur.is_return && !ras_empty;
	assign seq_addr   = cur.pc + (cur.is_rvc ? 64'd2 : 64'd4);
	assign taken_addr = use_ras ? ras_top :
	                    cur.is_jalr ? res.jalr_target : cur.pc + cur.imm;
	assign pred_taken = cur.is_jal || cur.is_jalr || (cur.is_branch && cur.imm[63]);
	assign next_addr  = pred_taken ? taken_addr : seq_addr;

	assign jalr_stall  = cur.is_jalr && !use_ras && !res.jalr_valid;
	assign queue_stall = cur.is_branch && q_full;

	// the head record always belongs to the oldest unresolved branch
	assign mispredict    = res.bru_valid && (res.bru_taken != head.taken) && !exc_valid;
	assign redirect      = exc_valid || mispredict;
	assign redirect_addr = exc_valid ? exc_pc : head.alt;

	assign issue = cur_valid && !jalr_stall && !queue_stall && !redirect;

	assign rec.taken = pred_taken;
	assign rec.alt   = pred_taken ? seq_addr : taken_addr;  // the path not chosen

	assign ras_push = issue && cur.is_call && (cur.is_jal || cur.is_jalr);
	assign ras_pop  = issue && use_ras && cur.is_jalr;

	always_ff @(posedge CLK) begin
		if (rst) begin
			req.addr     <= reset_vector;
			req.epoch    <= 1'b0;
			req_valid    <= 1'b0;
			boot_q       <= 1'b1;
			redir_q      <= 1'b0;
			pend_valid_q <= 1'b0;
		end else begin
			boot_q    <= 1'b0;
			redir_q   <= redirect;
			req_valid <= boot_q || redirect || issue;
			if (redirect) begin
				req.addr     <= redirect_addr;
				req.epoch    <= ~req.epoch;  // marks the fetch in flight as stale
				pend_valid_q <= 1'b0;
			end else if (issue) begin
				req.addr     <= next_addr;
				pend_valid_q <= 1'b0;
			end else if (cur_valid) begin
				pend_valid_q <= 1'b1;  // stalled on jalr target or a full queue
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (cur_valid)
			pend_q <= cur;
	end

	pred_queue #(.aw(queue_aw)) u_queue (
		.CLK(CLK), .rst(rst),
		.push(issue && cur.is_branch), .pop(res.bru_valid), .flush(redirect),
		.push_data(rec), .pop_data(head),
		.full(q_full), .empty()
	);

	return_stack #(.aw(stack_aw)) u_ras (
		.CLK(CLK), .rst(rst),
		.push(ras_push), .pop(ras_pop), .flush(redirect),
		.push_addr(seq_addr), .top_addr(ras_top), .empty(ras_empty)
	);

endmodule

//--- logic/decode_pkg.sv
/*
  Predecode and branch resolution types. resolve_t is driven from outside the
  front end, one bru pulse per branch and in program order
*/
package decode_pkg;

	import fetch_pkg::*;

	typedef logic [63:0] imm_t;  // sign-extended control flow offset

	// one entry of the prediction queue
	typedef struct packed {
		logic  taken;  // direction that was predicted
		addr_t alt;    // address to resume at if the prediction is wrong
	} pred_rec_t;

	// control flow summary of one fetched instruction
	typedef struct packed {
		logic  is_jal;
		logic  is_jalr;
		logic  is_branch;
		logic  is_call;    // link register written
		logic  is_return;  // jalr through a link register to x0
		logic  is_rvc;     // 16-bit encoding in the low half
		imm_t  imm;        // zero for jalr
		addr_t pc;
	} predec_t;

	// outcome reported by the branch unit
	typedef struct packed {
		logic  bru_valid;    // one-cycle pulse per branch
		logic  bru_taken;
		logic  jalr_valid;   // held until the front end moves on
		addr_t jalr_target;
	} resolve_t;

endpackage

//--- logic/fetch_pkg.sv
/*
  Types shared by the fetch path. Addresses are 64 bits and memory returns one
  32-bit word per fetch, so a compressed instruction is only seen at a word address
*/
package fetch_pkg;

	typedef logic [63:0] addr_t;   // instruction address
	typedef logic [31:0] inst_t;   // one fetched word

	// request from the address generator to the memory port
	typedef struct packed {
		addr_t addr;   // word to fetch
		logic  epoch;  // flips on every redirect
	} fetch_req_t;

	// completed fetch handed to predecode
	typedef struct packed {
		addr_t addr;   // address the word was fetched from
		inst_t inst;   // raw instruction word
	} fetch_rsp_t;

endpackage

//--- logic/frontend_top.sv
/*
  Fetch front end with one fetch in flight. Resolution and exceptions come from
  outside; the memory must follow the four-phase req/ack order
*/
`timescale 1ns/1ns

module frontend_top import fetch_pkg::*; import decode_pkg::*; #(
	parameter addr_t reset_vector = 64'h8000_0000,
	parameter int    queue_aw     = 2,
	parameter int    stack_aw     = 2
) (
	input  logic     CLK,
	input  logic     rst,
	input  logic     mem_ack,
	input  inst_t    mem_data,
	input  resolve_t res,
	input  logic     exc_valid,
	input  addr_t    exc_pc,
	output logic     mem_req,
	output addr_t    mem_addr,
	output logic     mispredict
);

	fetch_req_t req;
	logic       req_valid;
	fetch_rsp_t rsp;
	logic       rsp_valid;
	predec_t    pd;
	logic       pd_valid;

	branch_predict #(
		.reset_vector(reset_vector), .queue_aw(queue_aw), .stack_aw(stack_aw)
	) u_bp (
		.CLK(CLK), .rst(rst), .pd(pd), .pd_valid(pd_valid), .res(res),
		.exc_valid(exc_valid), .exc_pc(exc_pc),
		.req(req), .req_valid(req_valid), .mispredict(mispredict)
	);

	imem_port u_mem (
		.CLK(CLK), .rst(rst), .req(req), .req_valid(req_valid),
		.mem_ack(mem_ack), .mem_data(mem_data),
		.epoch(req.epoch),  // the generator's live epoch
		.mem_req(mem_req), .mem_addr(mem_addr), .rsp(rsp), .rsp_valid(rsp_valid)
	);

	predecode u_pd (
		.CLK(CLK), .rst(rst), .rsp(rsp), .rsp_valid(rsp_valid),
		.pd(pd), .pd_valid(pd_valid)
	);

endmodule

//--- logic/imem_port.sv
/*
  Four-phase req/ack fetch of one word. A request that arrives while busy waits
  in a single slot, and a newer one replaces it. Stale-epoch words are dropped
*/
`timescale 1ns/1ns

module imem_port import fetch_pkg::*; (
	input  logic       CLK,
	input  logic       rst,
	input  fetch_req_t req,
	input  logic       req_valid,
	input  logic       mem_ack,
	input  inst_t      mem_data,
	input  logic       epoch,
	output logic       mem_req,
	output addr_t      mem_addr,
	output fetch_rsp_t rsp,
	output logic       rsp_valid
);

	typedef enum logic [1:0] {idle, wait_ack, wait_release} state_t;

	state_t     state_q;
	fetch_req_t cur_q;        // request on the bus
	fetch_req_t pend_q;       // request that came in while busy
	logic       pend_valid_q;
	logic       done_q;       // word latched last cycle
	inst_t      data_q;

	assign mem_req   = (state_q == wait_ack);
	assign mem_addr  = cur_q.addr;
	assign rsp.addr  = cur_q.addr;
	assign rsp.inst  = data_q;
	assign rsp_valid = done_q && (cur_q.epoch == epoch);  // a redirect overtook it

	always_ff @(posedge CLK) begin
		if (rst) begin
			state_q      <= idle;
			pend_valid_q <= 1'b0;
			done_q       <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				idle: if (req_valid || pend_valid_q) begin
					state_q      <= wait_ack;
					pend_valid_q <= 1'b0;
				end
				wait_ack: if (mem_ack) begin
					state_q <= wait_release;
					done_q  <= 1'b1;
				end
				wait_release: if (!mem_ack)
					state_q <= idle;
				default: state_q <= idle;
			endcase
			if (req_valid && state_q != idle)
				pend_valid_q <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (state_q == idle)
			cur_q <= req_valid ? req : pend_q;  // newest request wins
		if (req_valid && state_q != idle)
			pend_q <= req;
		if (state_q == wait_ack && mem_ack)
			data_q <= mem_data;
	end

	assert property (@(posedge CLK) disable iff (rst) $fell(mem_ack) |-> !mem_req)
		else $error("mem_ack released before mem_req dropped");
	assert property (@(posedge CLK) disable iff (rst) $rose(mem_req) |-> !$past(mem_ack))
		else $error("mem_req raised while ack still high");

endmodule

//--- logic/pred_queue.sv
/*
  Circular queue of prediction records. pop_data shows the head combinationally
  and flush empties the queue in one cycle, winning over push and pop
*/
`timescale 1ns/1ns

module pred_queue import decode_pkg::*; #(
	parameter int aw = 2
) (
	input  logic      CLK,
	input  logic      rst,
	input  logic      push,
	input  logic      pop,
	input  logic      flush,
	input  pred_rec_t push_data,
	output pred_rec_t pop_data,
	output logic      full,
	output logic      empty
);

	localparam int depth = 1 << aw;

	pred_rec_t mem [depth];
	logic [aw:0] wr_q;  // extra msb tells full from empty
	logic [aw:0] rd_q;

	assign empty    = (wr_q == rd_q);
	assign full     = (wr_q[aw] != rd_q[aw]) && (wr_q[aw-1:0] == rd_q[aw-1:0]);
	assign pop_data = mem[rd_q[aw-1:0]];

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_q <= '0;
			rd_q <= '0;
		end else if (flush) begin
			wr_q <= '0;
			rd_q <= '0;
		end else begin
			if (push)
				wr_q <= wr_q + 1'b1;
			if (pop)
				rd_q <= rd_q + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push && !flush)
			mem[wr_q[aw-1:0]] <= push_data;
	end

	// the address generator stalls on a full queue, and the branch unit only
	// resolves branches that were predicted
	assert property (@(posedge CLK) disable iff (rst) !(push && full))
		else $error("prediction queue overflow");
	assert property (@(posedge CLK) disable iff (rst) !(pop && empty))
		else $error("branch resolved with no prediction outstanding");

endmodule

//--- logic/predecode.sv
/*
  One-cycle predecode of the fetched word. Only the low half is checked for a
  compressed encoding, and c.jal uses its RV32C slot
*/
`timescale 1ns/1ns

module predecode import fetch_pkg::*; import decode_pkg::*; (
	input  logic       CLK,
	input  logic       rst,
	input  fetch_rsp_t rsp,
	input  logic       rsp_valid,
	output predec_t    pd,
	output logic       pd_valid
);

	inst_t       inst;
	logic [15:0] c;
	predec_t     d;

	// x1 and x5 are the link registers of the calling convention
	function automatic logic is_link(input logic [4:0] r);
		return (r == 5'd1) || (r == 5'd5);
	endfunction

	assign inst = rsp.inst;
	assign c    = inst[15:0];

	always_comb begin
		d        = '0;
		d.pc     = rsp.addr;
		d.is_rvc = (inst[1:0] != 2'b11);
		if (d.is_rvc) begin
			if (c[1:0] == 2'b01 && c[14:13] == 2'b01) begin  // c.j and c.jal
				d.is_jal  = 1'b1;
				d.is_call = !c[15];
				d.imm     = {{52{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11],
				             c[5:3], 1'b0};
			end else if (c[1:0] == 2'b01 && c[15:14] == 2'b11) begin  // c.beqz, c.bnez
				d.is_branch = 1'b1;
				d.imm       = {{55{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
			end else if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && c[11:7] != 5'd0
			             && c[6:2] == 5'd0) begin  // c.jr and c.jalr
				d.is_jalr   = 1'b1;
				d.is_call   = c[12];
				d.is_return = !c[12] && is_link(c[11:7]);
			end
		end else begin
			case (inst[6:0])
				7'b1101111: begin  // jal
					d.is_jal  = 1'b1;
					d.is_call = is_link(inst[11:7]);
					d.imm     = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21],
					             1'b0};
				end
				7'b1100111: begin  // jalr, target comes from the stack or outside
					d.is_jalr   = 1'b1;
					d.is_call   = is_link(inst[11:7]);
					d.is_return = is_link(inst[19:15]) && (inst[11:7] == 5'd0);
				end
				7'b1100011: begin
					d.is_branch = 1'b1;
					d.imm       = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8],
					               1'b0};
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (rst)
			pd_valid <= 1'b0;
		else
			pd_valid <= rsp_valid;
	end

	always_ff @(posedge CLK) begin
		if (rsp_valid)
			pd <= d;
	end

endmodule

//--- logic/return_stack.sv
/*
  Ring-buffer return address stack. When full a push overwrites the oldest entry,
  so a chain deeper than the stack mispredicts only its outermost returns
*/
`timescale 1ns/1ns

module return_stack import fetch_pkg::*; #(
	parameter int aw = 2
) (
	input  logic  CLK,
	input  logic  rst,
	input  logic  push,
	input  logic  pop,
	input  logic  flush,
	input  addr_t push_addr,
	output addr_t top_addr,
	output logic  empty
);

	localparam int depth = 1 << aw;

	addr_t mem [depth];
	logic [aw-1:0] top_q;   // slot of the newest entry
	logic [aw:0]   count_q; // saturates at depth
	logic [aw-1:0] wr_idx;

	assign top_addr = mem[top_q];
	assign empty    = (count_q == '0);
	assign wr_idx   = pop ? top_q : top_q + 1'b1;  // push with pop replaces the top

	always_ff @(posedge CLK) begin
		if (rst) begin
			top_q   <= '0;
			count_q <= '0;
		end else if (flush) begin
			top_q   <= '0;
			count_q <= '0;
		end else if (push && !pop) begin
			top_q <= top_q + 1'b1;
			if (count_q != (aw+1)'(depth))
				count_q <= count_q + 1'b1;
		end else if (pop && !push) begin
			top_q   <= top_q - 1'b1;
			count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push && !flush)
			mem[wr_idx] <= push_addr;
	end

	// returns are only predicted through a non-empty stack
	assert property (@(posedge CLK) disable iff (rst) !(pop && empty))
		else $error("return stack popped while empty");

endmodule

//--- run.sh
#!/bin/sh
# build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module frontend_tb -Mdir obj_dir -o frontend_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/frontend_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	exit 1
fi
if echo "$out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1

//--- src.f
logic/fetch_pkg.sv
logic/decode_pkg.sv
logic/pred_queue.sv
logic/return_stack.sv
logic/branch_predict.sv
logic/imem_port.sv
logic/predecode.sv
logic/frontend_top.sv
tb/frontend_tb.sv

//--- tb/frontend_tb.sv
/*
  Testbench for the fetch front end. Branches resolve four fetches after their own
  fetch, and memory answers after 0 to 3 cycles. Expected fetches come from walk_program
*/
`timescale 1ns/1ns

module frontend_tb import fetch_pkg::*; import decode_pkg::*;;

	localparam addr_t base   = 64'h8000_0000;
	localparam int    words  = 64;
	localparam int    nf     = 72;               // fetches checked
	localparam int    lag    = 4;                // rises between a branch and its bru pulse
	localparam addr_t jt     = base + 4 * 44;    // target handed out for the plain jalr
	localparam addr_t exc_at = base + 4 * 49;    // fetch overtaken by the exception
	localparam addr_t exc_to = base + 4 * 52;
	localparam int    k_nop  = 0;
	localparam int    k_jal  = 1;
	localparam int    k_br   = 2;
	localparam int    k_jalr = 3;

	typedef struct packed {
		logic  taken;
		addr_t alt;
		int    idx;
	} pend_t;

	logic     CLK = 1'b0;
	logic     rst;
	logic     mem_ack;
	inst_t    mem_data;
	resolve_t res;
	logic     exc_valid;
	addr_t    exc_pc;
	logic     mem_req;
	addr_t    mem_addr;
	logic     mispredict;

	inst_t  prog [words];
	int     kind [words];
	longint offs [words];
	logic   link [words];
	logic   ret [words];
	logic   rvc [words];
	logic   outcomes [8] = '{0, 1, 0, 1, 1, 0, 1, 0};  // real branches in program order

	addr_t exp_addr [nf];
	logic  bru_at [nf];
	logic  bru_tk [nf];
	logic  misp_at [nf];
	logic  exc_hit [nf];
	logic  jwait [nf];

	logic  misp_exp = 1'b0;
	logic  req_seen;
	logic  rise;
	logic  jalr_wait;
	int    jalr_cnt;
	int    n;

	frontend_top #(.reset_vector(base), .queue_aw(2), .stack_aw(2)) dut (
		.CLK(CLK), .rst(rst), .mem_ack(mem_ack), .mem_data(mem_data), .res(res),
		.exc_valid(exc_valid), .exc_pc(exc_pc),
		.mem_req(mem_req), .mem_addr(mem_addr), .mispredict(mispredict)
	);

	always #10 CLK = ~CLK;

	task automatic check_value(input string name, input logic [63:0] got,
	                           input logic [63:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Verification failed");
			$fatal(1, "first mismatch ends the run");
		end
	endtask

	task automatic stop_run(input string why);
		$display("%s at %0t ns", why, $time);
		$display("Verification failed");
		$fatal(1, "run aborted");
	endtask

	function automatic inst_t fill_word(input addr_t a);
		logic [11:0] h;
		h = a[13:2] ^ a[25:14] ^ a[37:26] ^ a[49:38] ^ a[61:50] ^ {10'd0, a[63:62]};
		return {h, 20'h00013};  // addi x0, x0, h
	endfunction

	function automatic inst_t enc_jal(input logic [4:0] rd, input int off);
		logic [20:0] o;
		o = off[20:0];
		return {o[20], o[10:1], o[11], o[19:12], rd, 7'h6f};
	endfunction

	function automatic inst_t enc_br(input int off);
		logic [12:0] o;
		o = off[12:0];
		return {o[12], o[10:5], 5'd0, 5'd0, 3'b000, o[4:1], o[11], 7'h63};  // beq x0, x0
	endfunction

	function automatic inst_t enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
		return {12'd0, rs1, 3'b000, rd, 7'h67};
	endfunction

	// c.j when f3 is 101, c.jal when f3 is 001
	function automatic logic [15:0] enc_cj(input logic [2:0] f3, input int off);
		logic [11:0] o;
		o = off[11:0];
		return {f3, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01};
	endfunction

	function automatic logic [15:0] enc_cb(input logic bnez, input int off);
		logic [8:0] o;
		o = off[8:0];
		return {2'b11, bnez, o[8], o[4:3], 3'b000, o[7:6], o[2:1], o[5], 2'b01};
	endfunction

	task automatic put(input int i, input inst_t w, input int kd, input int off,
	                   input logic lk, input logic rt, input logic c);
		prog[i] = w;
		kind[i] = kd;
		offs[i] = off;
		link[i] = lk;
		ret[i]  = rt;
		rvc[i]  = c;
	endtask

	task automatic build_program();
		for (int i = 0; i < words; i++)
			put(i, fill_word(base + 4 * i), k_nop, 0, 0, 0, 0);
		put(1, 32'h0001_0001, k_nop, 0, 0, 0, 1);                  // two c.nop
		put(3, enc_br(12), k_br, 12, 0, 0, 0);
		put(8, enc_br(-8), k_br, -8, 0, 0, 0);                     // loop back to 6
		put(9, enc_br(8), k_br, 8, 0, 0, 0);
		put(15, enc_br(16), k_br, 16, 0, 0, 0);                    // four in a row fill the queue
		put(16, enc_br(8), k_br, 8, 0, 0, 0);
		put(17, enc_br(8), k_br, 8, 0, 0, 0);
		put(18, enc_br(8), k_br, 8, 0, 0, 0);
		put(20, enc_jal(5'd1, 16), k_jal, 16, 1, 0, 0);             // call chain four deep
		put(22, {16'h0001, enc_cj(3'b101, 72)}, k_jal, 72, 0, 0, 1);
		put(24, enc_jal(5'd1, 16), k_jal, 16, 1, 0, 0);
		put(25, enc_jalr(5'd0, 5'd1), k_jalr, 0, 0, 1, 0);
		put(28, {16'h0001, enc_cj(3'b001, 16)}, k_jal, 16, 1, 0, 1);
		put(29, enc_jalr(5'd0, 5'd1), k_jalr, 0, 0, 1, 0);
		put(32, enc_jal(5'd5, 16), k_jal, 16, 1, 0, 0);
		put(33, enc_jalr(5'd0, 5'd5), k_jalr, 0, 0, 1, 0);
		put(36, 32'h0001_8082, k_jalr, 0, 0, 1, 1);                // c.jr x1
		put(40, enc_jalr(5'd0, 5'd6), k_jalr, 0, 0, 0, 0);          // needs an outside target
		put(44, {16'h0001, enc_cb(1'b0, 8)}, k_br, 8, 0, 0, 1);
		put(54, {16'h0001, enc_cb(1'b1, -8)}, k_br, -8, 0, 0, 1);
		put(55, enc_jal(5'd0, 0), k_jal, 0, 0, 0, 0);                // spin here
	endtask

	// odd halfword addresses see the upper half of the word in the low position
	function automatic inst_t read_word(input addr_t a);
		inst_t w;
		if (a >= base && a < base + 4 * words)
			w = prog[int'((a - base) >> 2)];
		else
			w = fill_word({a[63:2], 2'b00});
		return a[1] ? {16'h0000, w[31:16]} : w;
	endfunction

	function automatic void walk_program();
		addr_t pc;
		addr_t seq;
		addr_t ras [$];
		pend_t pq [$];
		pend_t r;
		int    k;
		int    oc;
		logic  tk;
		logic  exc_done;
		pc       = base;
		oc       = 0;
		exc_done = 1'b0;
		for (int i = 0; i < nf; i++) begin
			exp_addr[i] = pc;
			bru_at[i]   = 1'b0;
			bru_tk[i]   = 1'b0;
			misp_at[i]  = 1'b0;
			jwait[i]    = 1'b0;
			exc_hit[i]  = (pc == exc_at) && !exc_done;
			if (pq.size() > 0 && pq[0].idx + lag == i) begin
				r  = pq.pop_front();
				tk = (oc < 8) ? outcomes[oc] : r.taken;
				oc++;
				bru_at[i] = 1'b1;
				bru_tk[i] = tk;
				if (tk != r.taken && !exc_hit[i]) begin  // exception wins
					misp_at[i] = 1'b1;
					pc = r.alt;
					pq.delete();
					ras.delete();
					continue;
				end
			end
			if (exc_hit[i]) begin
				exc_done = 1'b1;
				pc = exc_to;
				pq.delete();
				ras.delete();
				continue;
			end
			k   = (pc >= base && pc < base + 4 * words) ? int'((pc - base) >> 2) : 0;
			seq = pc + ((pc[1] || rvc[k]) ? 64'd2 : 64'd4);
			if (pc[1] || kind[k] == k_nop) begin
				pc = seq;
			end else if (kind[k] == k_jal) begin
				if (link[k])
					ras.push_back(seq);
				pc = pc + addr_t'(offs[k]);
			end else if (kind[k] == k_br) begin
				r.taken = (offs[k] < 0);
				r.alt   = r.taken ? seq : pc + addr_t'(offs[k]);
				r.idx   = i;
				pq.push_back(r);
				pc = r.taken ? pc + addr_t'(offs[k]) : seq;
			end else begin
				if (ret[k] && ras.size() > 0) begin
					pc = ras.pop_back();
				end else begin
					jwait[i] = 1'b1;
					pc = jt;
				end
				if (link[k])
					ras.push_back(seq);
			end
			if (ras.size() > 4)
				void'(ras.pop_front());  // oldest return address is lost
		end
	endfunction

	// memory answers a request after a random delay and waits for req to drop
	initial begin
		int   delay;
		logic busy;
		mem_ack  = 1'b0;
		mem_data = '0;
		busy     = 1'b0;
		delay    = 0;
		forever begin
			@(posedge CLK);
			#2;
			if (rst) begin
				mem_ack = 1'b0;
			end else if (mem_ack) begin
				if (!mem_req)
					mem_ack = 1'b0;
			end else if (mem_req) begin
				if (!busy) begin
					busy  = 1'b1;
					delay = $urandom % 4;
				end
				if (delay == 0) begin
					mem_ack  = 1'b1;
					mem_data = read_word(mem_addr);
					busy     = 1'b0;
				end else begin
					delay--;
				end
			end
		end
	end

	always @(negedge CLK) begin
		if (!rst)
			check_value("mispredict", mispredict, misp_exp);
	end

	initial begin
		#(nf * 10 * 20 + 10 * 20);
		stop_run("watchdog expired before every expected fetch was seen");
	end

	initial begin
		void'($urandom(32'h22a3be5c));
		rst       = 1'b1;
		res       = '0;
		exc_valid = 1'b0;
		exc_pc    = '0;
		req_seen  = 1'b0;
		jalr_wait = 1'b0;
		jalr_cnt  = 0;
		n         = 0;
		build_program();
		walk_program();
		repeat (10) @(posedge CLK);
		#2 rst = 1'b0;
		while (n < nf) begin
			@(posedge CLK);
			#2;
			res.bru_valid = 1'b0;
			exc_valid     = 1'b0;
			misp_exp      = 1'b0;
			rise          = mem_req && !req_seen;
			req_seen      = mem_req;
			if (rise) begin
				if (jalr_wait && !res.jalr_valid)
					stop_run("a fetch started before the jalr target was given");
				jalr_wait      = 1'b0;
				res.jalr_valid = 1'b0;
				check_value("mem_addr", mem_addr, exp_addr[n]);
				if (bru_at[n]) begin
					res.bru_valid = 1'b1;
					res.bru_taken = bru_tk[n];
					misp_exp      = misp_at[n];
				end
				if (exc_hit[n]) begin
					exc_valid = 1'b1;
					exc_pc    = exc_to;
				end
				if (jwait[n]) begin
					jalr_wait = 1'b1;
					jalr_cnt  = 8;  // long enough for the jalr to reach predecode
				end
				n++;
			end else if (jalr_wait && !res.jalr_valid) begin
				if (jalr_cnt == 0) begin
					res.jalr_valid  = 1'b1;
					res.jalr_target = jt;
				end else begin
					jalr_cnt--;
				end
			end
		end
		$display("Verification passed");
		$finish;
	end

endmodule
